/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_attention_score
FILELIST  ?= attention_score.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

/* att_pkg.sv */
`include "att_settings.svh"

package att_pkg;

    // IEEE half precision without inf or NaN handling
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp16_t;

    typedef logic [`ATT_IDX_W-1:0] idx_t;

    typedef enum logic [1:0] {
        OP_WRITE_QUERY = 2'd0,
        OP_WRITE_KEY   = 2'd1,
        OP_RUN         = 2'd2,
        OP_READ_SCORE  = 2'd3
    } att_op_e;

    // Command port word
    typedef struct packed {
        att_op_e op;
        idx_t    row;
        idx_t    col;
        fp16_t   data;
    } att_cmd_t;

    // One element write into the store
    typedef struct packed {
        logic  en;
        idx_t  row;
        idx_t  col;
        fp16_t data;
    } elem_wr_t;

    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        MAC   = 3'd1,
        DRAIN = 3'd2,
        SCALE = 3'd3,
        ACK   = 3'd4
    } seq_state_e;

endpackage

/* att_settings.svh */
`ifndef ATT_SETTINGS_SVH
`define ATT_SETTINGS_SVH

////////////////////////////////////////
// Matrix geometry
////////////////////////////////////////

`define ATT_DIM     4
`define ATT_IDX_W   2

////////////////////////////////////////
// Half-precision layout
////////////////////////////////////////

`define FP_EXP_W    5
`define FP_FRAC_W   10
`define FP_BIAS     15

// Encoding of 0.5 as the scale 1/sqrt(4)
`define ATT_SCALE   16'h3800

`endif

/* attention_score.f */
+incdir+.
att_pkg.sv
fp16_mul.sv
fp16_add.sv
matrix_store.sv
score_sequencer.sv
attention_score.sv
tb_attention_score.sv

/* attention_score.sv */
`timescale 1ns/1ns

module attention_score (
    input  logic               clk,
    input  logic               rst,
    input  att_pkg::att_cmd_t  cmd,
    input  logic               cmd_req,
    output logic               cmd_ack,
    output att_pkg::fp16_t     rsp_data
);

    att_pkg::elem_wr_t query_wr;
    att_pkg::elem_wr_t key_wr;
    att_pkg::elem_wr_t score_wr;
    att_pkg::idx_t     q_row;
    att_pkg::idx_t     q_col;
    att_pkg::idx_t     k_row;
    att_pkg::idx_t     k_col;
    att_pkg::idx_t     s_row;
    att_pkg::idx_t     s_col;
    att_pkg::fp16_t    q_elem;
    att_pkg::fp16_t    k_elem;
    att_pkg::fp16_t    s_elem;
    att_pkg::fp16_t    mul_a;
    att_pkg::fp16_t    mul_b;
    att_pkg::fp16_t    mul_p;
    att_pkg::fp16_t    add_a;
    att_pkg::fp16_t    add_b;
    att_pkg::fp16_t    add_s;

    // Query, key and score arrays
    matrix_store store_i (
        .clk      (clk),
        .rst      (rst),
        .query_wr (query_wr),
        .key_wr   (key_wr),
        .score_wr (score_wr),
        .q_row    (q_row),
        .q_col    (q_col),
        .k_row    (k_row),
        .k_col    (k_col),
        .s_row    (s_row),
        .s_col    (s_col),
        .q_elem   (q_elem),
        .k_elem   (k_elem),
        .s_elem   (s_elem)
    );

    score_sequencer seq_i (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .rsp_data (rsp_data),
        .query_wr (query_wr),
        .key_wr   (key_wr),
        .score_wr (score_wr),
        .q_row    (q_row),
        .q_col    (q_col),
        .k_row    (k_row),
        .k_col    (k_col),
        .s_row    (s_row),
        .s_col    (s_col),
        .q_elem   (q_elem),
        .k_elem   (k_elem),
        .s_elem   (s_elem),
        .mul_a    (mul_a),
        .mul_b    (mul_b),
        .mul_p    (mul_p),
        .add_a    (add_a),
        .add_b    (add_b),
        .add_s    (add_s)
    );

    fp16_mul mul_i (
        .clk (clk),
        .rst (rst),
        .a   (mul_a),
        .b   (mul_b),
        .p   (mul_p)
    );

    fp16_add add_i (
        .clk (clk),
        .rst (rst),
        .a   (add_a),
        .b   (add_b),
        .s   (add_s)
    );

endmodule

/* attention_score_trace.txt */
// op row col data expect, all hex; expect is checked on reads only
// op 0 write query, 1 write key, 2 run, 3 read score
// Scores are zero after reset
3 1 2 0000 0000
3 3 3 0000 0000
// Query rows
0 0 0 4000 0000
0 0 1 4200 0000
0 1 0 3c00 0000
0 1 1 3c00 0000
0 2 2 5c00 0000
0 3 2 dc00 0000
0 3 3 1400 0000
// Key rows
1 0 0 3c00 0000
1 0 1 4000 0000
1 0 3 1c00 0000
1 1 0 3555 0000
1 1 1 ae66 0000
1 2 0 6800 0000
1 2 1 ae66 0000
1 3 2 6000 0000
1 3 3 1c00 0000
2 0 0 0000 0000
// Integer, truncated, clamped and flushed scores
3 0 0 0000 4400
3 0 1 0000 31de
3 0 2 0000 67ff
3 1 0 0000 3e00
3 1 1 0000 2f77
3 1 2 0000 63ff
3 2 3 0000 77ff
3 3 3 0000 f7ff
3 3 0 0000 0000
3 2 1 0000 0000
// Key row 1 becomes -1, 0.25
1 1 0 bc00 0000
1 1 1 3400 0000
2 0 0 0000 0000
3 0 1 0000 b900
3 1 1 0000 b600
3 0 0 0000 4400
3 0 2 0000 67ff
3 3 3 0000 f7ff
3 2 1 0000 0000

/* fp16_add.sv */
`timescale 1ns/1ns
`include "att_settings.svh"

module fp16_add (
    input  logic           clk,
    input  logic           rst,
    input  att_pkg::fp16_t a,
    input  att_pkg::fp16_t b,
    output att_pkg::fp16_t s
);

    // Hidden bit, fraction, then guard, round and sticky
    localparam int MW     = `FP_FRAC_W + 4;
    localparam int LOST_W = (1 << `FP_EXP_W) - 1;

    att_pkg::fp16_t       an;
    att_pkg::fp16_t       bn;
    att_pkg::fp16_t       x;
    att_pkg::fp16_t       y;
    att_pkg::fp16_t       s_next;
    logic [`FP_EXP_W-1:0] d;
    logic [MW-1:0]        mx;
    logic [MW-1:0]        y_shift;
    logic [MW-1:0]        y_al;
    logic [LOST_W-1:0]    y_lost;
    logic [MW:0]          sum;
    logic [MW:0]          sum_norm;
    logic [3:0]           lz;
    logic [`FP_EXP_W+1:0] e_top;
    logic [`FP_EXP_W+1:0] e_res;

    function automatic logic [3:0] lead_zeros(input logic [MW:0] v);
        logic [3:0] n;
        n = 4'(MW + 1);
        for (int i = 0; i <= MW; i++) begin
            if (v[i]) begin
                n = 4'(MW - i);
            end
        end
        return n;
    endfunction

    always_comb begin
        an = a;
        bn = b;
        if (a.exp == '0) begin
            an.frac = '0;
        end
        if (b.exp == '0) begin
            bn.frac = '0;
        end

        // x carries the larger magnitude
        if ({bn.exp, bn.frac} > {an.exp, an.frac}) begin
            x = bn;
            y = an;
        end else begin
            x = an;
            y = bn;
        end

        mx = {|x.exp, x.frac, 3'b000};
        d  = x.exp - y.exp;
        {y_shift, y_lost} = {{|y.exp, y.frac, 3'b000}, {LOST_W{1'b0}}} >> d;
        // Bits shifted out collapse into the sticky position
        y_al = y_shift | {{(MW-1){1'b0}}, |y_lost};

        // Sticky in the LSB also produces the borrow on subtraction
        if (x.sign == y.sign) begin
            sum = {1'b0, mx} + {1'b0, y_al};
        end else begin
            sum = {1'b0, mx} - {1'b0, y_al};
        end

        lz       = lead_zeros(sum);
        sum_norm = sum << lz;
        e_top    = {2'b00, x.exp} + 1'b1;
        e_res    = e_top - {3'b000, lz};

        s_next.sign = x.sign;
        s_next.exp  = e_res[`FP_EXP_W-1:0];
        s_next.frac = sum_norm[MW-1 -: `FP_FRAC_W];

        if (sum == '0) begin
            // Exact cancellation gives +0
            s_next      = '0;
            s_next.sign = x.sign & y.sign;
        end else if (e_top <= {3'b000, lz}) begin
            s_next.exp  = '0;
            s_next.frac = '0;
        end else if (e_res >= {2'b00, {`FP_EXP_W{1'b1}}}) begin
            s_next.exp  = {`FP_EXP_W{1'b1}} - 1'b1;
            s_next.frac = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s <= '0;
        end else begin
            s <= s_next;
        end
    end

endmodule

/* fp16_mul.sv */
`timescale 1ns/1ns
`include "att_settings.svh"

module fp16_mul (
    input  logic           clk,
    input  logic           rst,
    input  att_pkg::fp16_t a,
    input  att_pkg::fp16_t b,
    output att_pkg::fp16_t p
);

    logic [2*`FP_FRAC_W+1:0] prod;
    logic                    norm;
    logic [`FP_EXP_W+1:0]    e_sum;
    logic [`FP_EXP_W+1:0]    e_res;
    logic                    zero_in;
    att_pkg::fp16_t          p_next;

    always_comb begin
        // Subnormal operands count as zero
        zero_in = (a.exp == '0) || (b.exp == '0);
        prod    = {1'b1, a.frac} * {1'b1, b.frac};

        // Product of two 1.x significands lies in [1, 4)
        norm  = prod[2*`FP_FRAC_W+1];
        e_sum = {2'b00, a.exp} + {2'b00, b.exp} + {{(`FP_EXP_W+1){1'b0}}, norm};
        e_res = e_sum - (`FP_EXP_W+2)'(`FP_BIAS);

        p_next.sign = a.sign ^ b.sign;
        p_next.exp  = e_res[`FP_EXP_W-1:0];
        if (norm) begin
            p_next.frac = prod[2*`FP_FRAC_W -: `FP_FRAC_W];
        end else begin
            p_next.frac = prod[2*`FP_FRAC_W-1 -: `FP_FRAC_W];
        end

        if (zero_in || e_sum <= (`FP_EXP_W+2)'(`FP_BIAS)) begin
            // Flush to signed zero
            p_next.exp  = '0;
            p_next.frac = '0;
        end else if (e_res >= {2'b00, {`FP_EXP_W{1'b1}}}) begin
            // Clamp to largest finite
            p_next.exp  = {`FP_EXP_W{1'b1}} - 1'b1;
            p_next.frac = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            p <= '0;
        end else begin
            p <= p_next;
        end
    end

endmodule

/* matrix_store.sv */
`timescale 1ns/1ns
`include "att_settings.svh"

module matrix_store (
    input  logic               clk,
    input  logic               rst,
    input  att_pkg::elem_wr_t  query_wr,
    input  att_pkg::elem_wr_t  key_wr,
    input  att_pkg::elem_wr_t  score_wr,
    input  att_pkg::idx_t      q_row,
    input  att_pkg::idx_t      q_col,
    input  att_pkg::idx_t      k_row,
    input  att_pkg::idx_t      k_col,
    input  att_pkg::idx_t      s_row,
    input  att_pkg::idx_t      s_col,
    output att_pkg::fp16_t     q_elem,
    output att_pkg::fp16_t     k_elem,
    output att_pkg::fp16_t     s_elem
);

    att_pkg::fp16_t q_mem [`ATT_DIM][`ATT_DIM];
    att_pkg::fp16_t k_mem [`ATT_DIM][`ATT_DIM];
    att_pkg::fp16_t s_mem [`ATT_DIM][`ATT_DIM];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `ATT_DIM; r++) begin
                for (int c = 0; c < `ATT_DIM; c++) begin
                    q_mem[r][c] <= '0;
                    k_mem[r][c] <= '0;
                    s_mem[r][c] <= '0;
                end
            end
        end else begin
            if (query_wr.en) begin
                q_mem[query_wr.row][query_wr.col] <= query_wr.data;
            end
            if (key_wr.en) begin
                k_mem[key_wr.row][key_wr.col] <= key_wr.data;
            end
            if (score_wr.en) begin
                s_mem[score_wr.row][score_wr.col] <= score_wr.data;
            end
        end
    end

    // Asynchronous read ports
    assign q_elem = q_mem[q_row][q_col];
    assign k_elem = k_mem[k_row][k_col];
    assign s_elem = s_mem[s_row][s_col];

endmodule

/* score_sequencer.sv */
`timescale 1ns/1ns
`include "att_settings.svh"

module score_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  att_pkg::att_cmd_t  cmd,
    input  logic               cmd_req,
    output logic               cmd_ack,
    output att_pkg::fp16_t     rsp_data,
    output att_pkg::elem_wr_t  query_wr,
    output att_pkg::elem_wr_t  key_wr,
    output att_pkg::elem_wr_t  score_wr,
    output att_pkg::idx_t      q_row,
    output att_pkg::idx_t      q_col,
    output att_pkg::idx_t      k_row,
    output att_pkg::idx_t      k_col,
    output att_pkg::idx_t      s_row,
    output att_pkg::idx_t      s_col,
    input  att_pkg::fp16_t     q_elem,
    input  att_pkg::fp16_t     k_elem,
    input  att_pkg::fp16_t     s_elem,
    output att_pkg::fp16_t     mul_a,
    output att_pkg::fp16_t     mul_b,
    input  att_pkg::fp16_t     mul_p,
    output att_pkg::fp16_t     add_a,
    output att_pkg::fp16_t     add_b,
    input  att_pkg::fp16_t     add_s
);

    localparam logic [`ATT_IDX_W:0] LAST_STEP = (`ATT_IDX_W+1)'(`ATT_DIM);
    localparam att_pkg::idx_t       LAST_IDX  = att_pkg::idx_t'(`ATT_DIM - 1);

    att_pkg::seq_state_e state;
    att_pkg::att_cmd_t   cmd_q;
    att_pkg::idx_t       row_i;
    att_pkg::idx_t       col_k;
    att_pkg::idx_t       step_j;
    logic [`ATT_IDX_W:0] step;
    logic                ack_arm;

    assign step_j = step[`ATT_IDX_W-1:0];

    ////////////////////////////////////////
    // Store addressing and operand select
    ////////////////////////////////////////

    always_comb begin
        q_row = row_i;
        q_col = step_j;
        k_row = col_k;
        k_col = step_j;
        s_row = row_i;
        s_col = col_k;
        if (state == att_pkg::ACK) begin
            s_row = cmd_q.row;
            s_col = cmd_q.col;
        end

        mul_a = q_elem;
        mul_b = k_elem;
        if (state == att_pkg::SCALE) begin
            mul_a = s_elem;
            mul_b = `ATT_SCALE;
        end

        // First add of a score starts from +0
        add_a = (step == 1) ? '0 : add_s;
        add_b = mul_p;
    end

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        query_wr.en <= 1'b0;
        key_wr.en   <= 1'b0;
        score_wr.en <= 1'b0;
        if (rst) begin
            state   <= att_pkg::IDLE;
            cmd_ack <= 1'b0;
            ack_arm <= 1'b0;
            row_i   <= '0;
            col_k   <= '0;
            step    <= '0;
        end else begin
            case (state)
                att_pkg::IDLE: begin
                    if (cmd_req) begin
                        cmd_q <= cmd;
                        row_i <= '0;
                        col_k <= '0;
                        step  <= '0;
                        state <= att_pkg::ACK;
                        case (cmd.op)
                            att_pkg::OP_WRITE_QUERY:
                                query_wr <= '{1'b1, cmd.row, cmd.col, cmd.data};
                            att_pkg::OP_WRITE_KEY:
                                key_wr <= '{1'b1, cmd.row, cmd.col, cmd.data};
                            att_pkg::OP_RUN:
                                state <= att_pkg::MAC;
                            default: ;
                        endcase
                    end
                end

                // Multiply of step j+1 overlaps the add of step j
                att_pkg::MAC: begin
                    step <= step + 1'b1;
                    if (step == LAST_STEP) begin
                        step  <= '0;
                        state <= att_pkg::DRAIN;
                    end
                end

                att_pkg::DRAIN: begin
                    score_wr <= '{1'b1, row_i, col_k, add_s};
                    state    <= att_pkg::MAC;
                    col_k    <= col_k + 1'b1;
                    if (col_k == LAST_IDX) begin
                        col_k <= '0;
                        row_i <= row_i + 1'b1;
                        if (row_i == LAST_IDX) begin
                            row_i <= '0;
                            state <= att_pkg::SCALE;
                        end
                    end
                end

                // Even step issues the multiply, odd step writes back
                att_pkg::SCALE: begin
                    if (step == '0) begin
                        step <= (`ATT_IDX_W+1)'(1);
                    end else begin
                        step     <= '0;
                        score_wr <= '{1'b1, row_i, col_k, mul_p};
                        col_k    <= col_k + 1'b1;
                        if (col_k == LAST_IDX) begin
                            col_k <= '0;
                            row_i <= row_i + 1'b1;
                            if (row_i == LAST_IDX) begin
                                row_i <= '0;
                                state <= att_pkg::ACK;
                            end
                        end
                    end
                end

                att_pkg::ACK: begin
                    if (cmd_q.op == att_pkg::OP_READ_SCORE) begin
                        rsp_data <= s_elem;
                    end
                    // One settle cycle before ack rises
                    if (!cmd_ack) begin
                        ack_arm <= 1'b1;
                        if (ack_arm) begin
                            cmd_ack <= 1'b1;
                            ack_arm <= 1'b0;
                        end
                    end else if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= att_pkg::IDLE;
                    end
                end

                default: state <= att_pkg::IDLE;
            endcase
        end
    end

endmodule

/* tb_attention_score.sv */
`timescale 1ns/1ns
`include "att_settings.svh"

module tb_attention_score;

    localparam int MAX_CMDS    = 64;
    localparam int WORDS       = 5;
    // MAC and drain per score, two cycles per scale, handshake slack
    localparam int RUN_CYCLES  = `ATT_DIM * `ATT_DIM * (`ATT_DIM + 2)
                                 + 2 * `ATT_DIM * `ATT_DIM + 8;
    localparam int CMD_CYCLES  = RUN_CYCLES + 12;
    localparam int ACK_LATENCY = 2;

    logic              clk = 1'b0;
    logic              rst;
    att_pkg::att_cmd_t cmd;
    logic              cmd_req;
    logic              cmd_ack;
    att_pkg::fp16_t    rsp_data;

    // Five hex words per trace line
    logic [15:0] trace [WORDS*MAX_CMDS];
    logic [31:0] lfsr = 32'h19cf;
    int          n_cmds = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          reads_checked = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;

    attention_score dut_i (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .rsp_data (rsp_data)
    );

    always #5 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Simulation stopped after %0d cycles before the trace was done", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_command(input int idx);
        att_pkg::att_cmd_t c;
        logic [15:0]       exp_val;
        int                edges;
        int                hold;
        c.op    = att_pkg::att_op_e'(trace[WORDS*idx][1:0]);
        c.row   = trace[WORDS*idx+1][`ATT_IDX_W-1:0];
        c.col   = trace[WORDS*idx+2][`ATT_IDX_W-1:0];
        c.data  = trace[WORDS*idx+3];
        exp_val = trace[WORDS*idx+4];

        if (cmd_ack) begin
            $display("cmd_ack was already high before command %0d at %0t ns", idx, $time);
            protocol_errors++;
        end
        cmd     = c;
        cmd_req = 1'b1;
        edges   = 0;
        while (!cmd_ack) begin
            next_cycle();
            edges++;
        end

        // The first edge only samples the request
        if (c.op != att_pkg::OP_RUN && edges - 1 != ACK_LATENCY) begin
            $display("[ERROR] %0t ns: command %0d acked %0d cycles after request, expected %0d",
                     $time, idx, edges - 1, ACK_LATENCY);
            value_errors++;
        end
        if (c.op == att_pkg::OP_READ_SCORE) begin
            reads_checked++;
            if (rsp_data !== exp_val) begin
                $display("[ERROR] %0t ns: score (%0d,%0d) is %h, expected %h",
                         $time, c.row, c.col, rsp_data, exp_val);
                value_errors++;
            end
        end

        // Back-pressure by holding the request
        take_bits(2, hold);
        repeat (hold) begin
            next_cycle();
            if (!cmd_ack) begin
                $display("cmd_ack fell while the request of command %0d was held at %0t ns",
                         idx, $time);
                protocol_errors++;
            end
        end
        cmd_req = 1'b0;
        next_cycle();
        if (cmd_ack) begin
            $display("cmd_ack still high one cycle after command %0d was released at %0t ns",
                     idx, $time);
            protocol_errors++;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int gap;
        rst     = 1'b1;
        cmd_req = 1'b0;
        cmd     = '0;
        // Unwritten words carry f in the top nibble
        for (int i = 0; i < WORDS*MAX_CMDS; i++) begin
            trace[i] = 16'hf000 | 16'(i);
        end
        $readmemh("attention_score_trace.txt", trace);
        while (n_cmds < MAX_CMDS && trace[WORDS*n_cmds][15:12] != 4'hf) begin
            n_cmds++;
        end
        cycle_limit = n_cmds * CMD_CYCLES + 3 + 50;
        if (n_cmds == 0) begin
            $display("No commands were found in attention_score_trace.txt");
            protocol_errors++;
        end

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        if (cmd_ack) begin
            $display("cmd_ack is high right after reset");
            protocol_errors++;
        end

        for (int n = 0; n < n_cmds; n++) begin
            take_bits(2, gap);
            repeat (gap) begin
                next_cycle();
            end
            send_command(n);
        end

        next_cycle();
        $display("Reads checked: %0d, value errors: %0d, protocol errors: %0d",
                 reads_checked, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
